/* flist.f */
logic/rvPkg.sv
logic/controlUnit.sv
logic/immGen.sv
logic/regFile.sv
logic/alu.sv
logic/branchUnit.sv
logic/writeBack.sv
logic/rvCore.sv
testbench/clockGen.sv
testbench/rvCoreTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= rvCoreTb
FLIST ?= flist.f
BUILD ?= obj_dir
VFLAGS ?= --binary --timing -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
BIN := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD)

/* testbench/rvCoreTb.sv */
module rvCoreTb;
	import rvPkg::*;

	typedef struct packed {
		xlenT pc;                                    // Expected pc of the step
		logic we;                                    // Store expected
		logic re;                                    // Load expected
		memTypeT mt;                                 // Width code of the access
		xlenT addr;
		xlenT data;
	} stepT;

	localparam instrT nop = 32'h00000013;            // ADDI x0, x0, 0

	logic clk;
	logic rstN;
	instrT instr;
	xlenT memRData;
	xlenT pc;
	xlenT memAddr;
	xlenT memWData;
	logic memRead;
	logic memWrite;
	memTypeT memType;

	instrT prog[$];                                  // Instruction memory image
	stepT steps[$];                                  // Executed steps in order
	xlenT dmem [0:63];
	xlenT slot;                                      // Next result store address
	xlenT w0;
	xlenT w1;
	int seed;
	int cycles = 0;
	int cycleLimit;

	clockGen clockGen_inst (.clk(clk));

	rvCore rvCore_inst (
		.clk      (clk),
		.rstN     (rstN),
		.instr    (instr),
		.memRData (memRData),
		.pc       (pc),
		.memAddr  (memAddr),
		.memWData (memWData),
		.memRead  (memRead),
		.memWrite (memWrite),
		.memType  (memType)
	);

	//////////////////////////////
	// Data memory model
	//////////////////////////////
	assign memRData = dmem[memAddr[7:2]];            // Same-cycle read

	always @(posedge clk) begin
		if (rstN && memWrite) begin
			case (memType)
				memByte: dmem[memAddr[7:2]][{memAddr[1:0], 3'b000} +: 8] <= memWData[7:0];
				memHalf: dmem[memAddr[7:2]][{memAddr[1], 4'b0000} +: 16] <= memWData[15:0];
				default: dmem[memAddr[7:2]] <= memWData;
			endcase
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > cycleLimit) begin
			$display("Timeout: the program did not finish within %0d cycles", cycleLimit);
			$display("Simulation FAILED");
			$fatal(1, "Timeout");
		end
	end

	//////////////////////////////
	// Instruction encoders
	//////////////////////////////
	function automatic instrT rType(input xlenT f7, rs2, rs1, f3, rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opReg};
	endfunction

	function automatic instrT iType(input xlenT imm, rs1, f3, rd, input logic [6:0] op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
	endfunction

	function automatic instrT sType(input xlenT imm, rs2, rs1, f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], opStore};
	endfunction

	function automatic instrT bType(input xlenT imm, rs2, rs1, f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], opBranch};
	endfunction

	function automatic instrT uType(input xlenT imm, rd, input logic [6:0] op);
		return {imm[19:0], rd[4:0], op};
	endfunction

	function automatic instrT jType(input xlenT imm, rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opJal};
	endfunction

	function automatic xlenT fillWord(input int idx);
		return 32'hA5A50000 ^ xlenT'(idx * 4);       // Byte address in low bits
	endfunction

	function automatic xlenT curAddr();
		return xlenT'(prog.size() * 4);
	endfunction

	function automatic instrT fetch(input xlenT a);
		int idx;
		idx = int'(a >> 2);
		if (idx < prog.size()) begin
			return prog[idx];
		end
		return nop;                                  // Past the end of the program
	endfunction

	task automatic addStep(input instrT ins, input logic exec, input logic we,
			input logic re, input memTypeT mt, input xlenT addr, input xlenT data);
		stepT s;
		s.pc = curAddr();
		s.we = we;
		s.re = re;
		s.mt = mt;
		s.addr = addr;
		s.data = data;
		prog.push_back(ins);
		if (exec) begin
			steps.push_back(s);
		end
	endtask

	task automatic run(input instrT ins);
		addStep(ins, 1'b1, 1'b0, 1'b0, '0, '0, '0);
	endtask

	task automatic skip(input instrT ins);
		addStep(ins, 1'b0, 1'b0, 1'b0, '0, '0, '0);  // Jumped over and never executed
	endtask

	task automatic runLoad(input instrT ins, input xlenT addr, input memTypeT mt);
		addStep(ins, 1'b1, 1'b0, 1'b1, mt, addr, '0);
	endtask

	task automatic storeCheck(input xlenT rs2, input xlenT exp);
		addStep(sType(slot, rs2, 0, 2), 1'b1, 1'b1, 1'b0, memWord, slot, exp);
		slot = slot + 32'd4;
	endtask

	task automatic check(input xlenT got, input xlenT exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "Check failed");
		end
	endtask

	//////////////////////////////
	// Program and expectations
	//////////////////////////////
	task automatic buildProgram();
		xlenT c1;
		xlenT c2;
		xlenT at;
		instrT bump;
		c1 = (32'h12345 << 12) + 32'h678;            // LUI then ADDI
		c2 = (32'hFFFFF << 12) + 32'hFFFFFFF0;       // ADDI -16 sign-extended
		bump = iType(1, 7, 0, 7, opImm);             // Bumps x7 only on a wrong path
		slot = 32'h40;
		run(uType(32'h12345, 1, opLui));
		run(iType(32'h678, 1, 0, 1, opImm));
		run(uType(32'hFFFFF, 2, opLui));
		run(iType(-16, 2, 0, 2, opImm));
		run(iType(5, 0, 0, 3, opImm));               // x3 = 5, shift amount
		storeCheck(1, c1);
		storeCheck(2, c2);
		run(rType(0, 2, 1, 0, 4));
		storeCheck(4, c1 + c2);
		run(rType(32'h20, 2, 1, 0, 4));
		storeCheck(4, c1 - c2);
		run(rType(0, 1, 2, 2, 4));                   // Negative < positive
		storeCheck(4, 32'd1);
		run(rType(0, 1, 2, 3, 4));                   // Unsigned with x2 larger
		storeCheck(4, 32'd0);
		run(rType(0, 2, 1, 4, 4));
		storeCheck(4, c1 ^ c2);
		run(rType(0, 2, 1, 6, 4));
		storeCheck(4, c1 | c2);
		run(rType(0, 2, 1, 7, 4));
		storeCheck(4, c1 & c2);
		run(rType(0, 3, 1, 1, 4));
		storeCheck(4, c1 << 5);
		run(rType(0, 3, 2, 5, 4));
		storeCheck(4, c2 >> 5);
		run(rType(32'h20, 3, 2, 5, 4));
		storeCheck(4, {{5{c2[31]}}, c2[31:5]});
		// Loads of the random words
		runLoad(iType(1, 0, 0, 5, opLoad), 32'd1, memByte);
		storeCheck(5, {{24{w0[15]}}, w0[15:8]});
		runLoad(iType(1, 0, 4, 5, opLoad), 32'd1, memByteU);
		storeCheck(5, {24'b0, w0[15:8]});
		runLoad(iType(2, 0, 1, 5, opLoad), 32'd2, memHalf);
		storeCheck(5, {{16{w0[31]}}, w0[31:16]});
		runLoad(iType(0, 0, 5, 5, opLoad), 32'd0, memHalfU);
		storeCheck(5, {16'b0, w0[15:0]});
		runLoad(iType(4, 0, 2, 5, opLoad), 32'd4, memWord);
		storeCheck(5, w1);
		// SB into lane 1 of word 60
		addStep(sType(32'hF1, 1, 0, 0), 1'b1, 1'b1, 1'b0, memByte, 32'hF1, c1);
		runLoad(iType(32'hF0, 0, 2, 6, opLoad), 32'hF0, memWord);
		storeCheck(6, (fillWord(60) & 32'hFFFF00FF) | 32'h00007800);
		// Branches taken then not taken
		run(bType(8, 3, 3, 0));
		skip(bump);
		run(bType(8, 0, 3, 0));
		run(bType(8, 0, 3, 1));
		skip(bump);
		run(bType(8, 3, 3, 1));
		run(bType(8, 1, 2, 4));
		skip(bump);
		run(bType(8, 2, 1, 4));
		run(bType(8, 1, 2, 7));
		skip(bump);
		run(bType(8, 2, 1, 7));
		// Jumps and AUIPC
		at = curAddr();
		run(jType(12, 8));
		skip(bump);
		skip(bump);
		storeCheck(8, at + 32'd4);
		at = curAddr();
		run(uType(0, 10, opAuipc));
		run(iType(13, 10, 0, 9, opJalr));            // Odd target with bit 0 dropped
		skip(bump);
		storeCheck(9, at + 32'd8);
		storeCheck(10, at);
		at = curAddr();
		run(uType(32'h12345, 11, opAuipc));
		storeCheck(11, at + 32'h12345000);
		run(iType(77, 0, 0, 0, opImm));
		storeCheck(0, 32'd0);
		storeCheck(7, 32'd0);                        // No skipped bump ran
	endtask

	initial begin
		seed = 42;
		rstN = 1'b0;
		instr = nop;
		for (int i = 0; i < 64; i++) begin
			dmem[i] <= fillWord(i);
		end
		w0 = $random(seed) | 32'h80008000;           // Sign bits set in both halves
		w1 = $random(seed);
		dmem[0] <= w0;
		dmem[1] <= w1;
		buildProgram();
		cycleLimit = steps.size() + 20;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		for (int i = 0; i < steps.size(); i++) begin
			check(pc, steps[i].pc, "pc");
			instr = fetch(pc);
			#10;
			check({31'b0, memWrite}, {31'b0, steps[i].we}, "memWrite");
			check({31'b0, memRead}, {31'b0, steps[i].re}, "memRead");
			if (steps[i].we || steps[i].re) begin
				check(memAddr, steps[i].addr, "memAddr");
				check({29'b0, memType}, {29'b0, steps[i].mt}, "memType");
			end
			if (steps[i].we) begin
				check(memWData, steps[i].data, "memWData");
			end
			@(negedge clk);
		end
		instr = nop;
		$display("Simulation PASSED");
		$finish;
	end

endmodule

/* testbench/clockGen.sv */
module clockGen (
	output logic clk
);

	localparam int halfPeriod = 50;                  // 100 unit period

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

endmodule

/* logic/rvCore.sv */
module rvCore (
	input logic clk,
	input logic rstN,
	input rvPkg::instrT instr,
	input rvPkg::xlenT memRData,
	output rvPkg::xlenT pc,
	output rvPkg::xlenT memAddr,
	output rvPkg::xlenT memWData,
	output logic memRead,
	output logic memWrite,
	output rvPkg::memTypeT memType
);
	import rvPkg::*;

	ctrlT ctrl;
	xlenT imm;
	xlenT rs1Data;
	xlenT rs2Data;
	xlenT aluA;                                      // ALU operand A
	xlenT aluB;                                      // ALU operand B
	xlenT aluResult;
	xlenT nextPc;
	xlenT wbData;

	//////////////////////////////
	// Program counter
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
		end else begin
			pc <= nextPc;                              // One instruction per cycle
		end
	end

	controlUnit controlUnit_inst (
		.instr (instr),
		.ctrl  (ctrl)
	);

	immGen immGen_inst (
		.instr   (instr),
		.immType (ctrl.immType),
		.imm     (imm)
	);

	regFile regFile_inst (
		.clk     (clk),
		.rstN    (rstN),
		.rs1     (ctrl.rs1),
		.rs2     (ctrl.rs2),
		.rd      (ctrl.rd),
		.wrEn    (ctrl.regWriteEnable),
		.wrData  (wbData),
		.rs1Data (rs1Data),
		.rs2Data (rs2Data)
	);

	// Operand muxes
	assign aluA = ctrl.setDataZero ? '0 : (ctrl.pcOperand ? pc : rs1Data);
	assign aluB = ctrl.immSel ? imm : rs2Data;

	alu alu_inst (
		.aluOp  (ctrl.aluOp),
		.a      (aluA),
		.b      (aluB),
		.result (aluResult)
	);

	branchUnit branchUnit_inst (
		.pc        (pc),
		.imm       (imm),
		.rs1Data   (rs1Data),
		.rs2Data   (rs2Data),
		.aluResult (aluResult),
		.ctrl      (ctrl),
		.nextPc    (nextPc)
	);

	writeBack writeBack_inst (
		.aluResult (aluResult),
		.pc        (pc),
		.memRData  (memRData),
		.ctrl      (ctrl),
		.wbData    (wbData)
	);

	//////////////////////////////
	// Data port
	//////////////////////////////
	assign memAddr = aluResult;                      // Unaligned byte address
	assign memWData = rs2Data;                       // Lane placement done by memory
	assign memRead = ctrl.memRead;
	assign memWrite = ctrl.memWrite;
	assign memType = ctrl.memType;

endmodule

/* logic/writeBack.sv */
module writeBack (
	input rvPkg::xlenT aluResult,
	input rvPkg::xlenT pc,
	input rvPkg::xlenT memRData,
	input rvPkg::ctrlT ctrl,
	output rvPkg::xlenT wbData
);
	import rvPkg::*;

	logic [7:0] loadByte;                            // Addressed byte lane
	logic [15:0] loadHalf;                           // Addressed half lane
	xlenT loadData;                                  // Extended load value

	assign loadByte = memRData[{aluResult[1:0], 3'b000} +: 8];
	assign loadHalf = memRData[{aluResult[1], 4'b0000} +: 16];

	always_comb begin
		case (ctrl.memType)
			memByte: loadData = {{24{loadByte[7]}}, loadByte};
			memHalf: loadData = {{16{loadHalf[15]}}, loadHalf};
			memByteU: loadData = {24'b0, loadByte};
			memHalfU: loadData = {16'b0, loadHalf};
			memWord: loadData = memRData;
			default: loadData = memRData;              // Reserved codes as word
		endcase
	end

	// Link value wins, then load, then ALU
	always_comb begin
		if (ctrl.addConstant4) begin
			wbData = pc + pcStep;
		end else if (ctrl.memRead) begin
			wbData = loadData;
		end else begin
			wbData = aluResult;
		end
	end

endmodule

/* logic/branchUnit.sv */
module branchUnit (
	input rvPkg::xlenT pc,
	input rvPkg::xlenT imm,
	input rvPkg::xlenT rs1Data,
	input rvPkg::xlenT rs2Data,
	input rvPkg::xlenT aluResult,
	input rvPkg::ctrlT ctrl,
	output rvPkg::xlenT nextPc
);
	import rvPkg::*;

	logic cond;                                      // Branch condition true

	always_comb begin
		case (ctrl.funct3)
			3'b000: cond = rs1Data == rs2Data;         // BEQ
			3'b001: cond = rs1Data != rs2Data;         // BNE
			3'b100: cond = $signed(rs1Data) < $signed(rs2Data);   // BLT
			3'b101: cond = $signed(rs1Data) >= $signed(rs2Data);  // BGE
			3'b110: cond = rs1Data < rs2Data;          // BLTU
			3'b111: cond = rs1Data >= rs2Data;         // BGEU
			default: cond = 1'b0;
		endcase
	end

	//////////////////////////////
	// Next pc select
	//////////////////////////////
	always_comb begin
		if (ctrl.branch && cond) begin
			nextPc = pc + imm;                         // Taken branch
		end else if (ctrl.jump && ctrl.jumpAL) begin
			nextPc = aluResult;                        // JAL, pc + imm
		end else if (ctrl.jump) begin
			nextPc = {aluResult[xlen-1:1], 1'b0};      // JALR clears bit 0
		end else begin
			nextPc = pc + pcStep;
		end
	end

endmodule

/* logic/alu.sv */
module alu (
	input rvPkg::aluOpT aluOp,
	input rvPkg::xlenT a,
	input rvPkg::xlenT b,
	output rvPkg::xlenT result
);
	import rvPkg::*;

	logic [4:0] shamt;                               // Low five bits of b
	logic ltSigned;
	logic ltUnsigned;

	assign shamt = b[4:0];
	assign ltSigned = $signed(a) < $signed(b);
	assign ltUnsigned = a < b;

	always_comb begin
		case (aluOp)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluSll: result = a << shamt;
			aluSlt: result = {{(xlen-1){1'b0}}, ltSigned};
			aluSltu: result = {{(xlen-1){1'b0}}, ltUnsigned};
			aluXor: result = a ^ b;
			aluSrl: result = a >> shamt;
			aluSra: result = $signed(a) >>> shamt;    // Sign bit shifted in
			aluOr: result = a | b;
			aluAnd: result = a & b;
			default: result = '0;
		endcase
	end

endmodule

/* logic/regFile.sv */
module regFile (
	input logic clk,
	input logic rstN,
	input rvPkg::regIdxT rs1,
	input rvPkg::regIdxT rs2,
	input rvPkg::regIdxT rd,
	input logic wrEn,
	input rvPkg::xlenT wrData,
	output rvPkg::xlenT rs1Data,
	output rvPkg::xlenT rs2Data
);
	import rvPkg::*;

	xlenT regs [1:numRegs-1];                        // x0 not stored

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 1; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && rd != '0) begin        // Drop writes to x0
			regs[rd] <= wrData;
		end
	end

	// Async read with x0 hardwired to zero
	assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* logic/immGen.sv */
module immGen (
	input rvPkg::instrT instr,
	input rvPkg::immTypeT immType,
	output rvPkg::xlenT imm
);
	import rvPkg::*;

	logic sign;                                      // Instruction sign bit

	assign sign = instr[31];

	//////////////////////////////
	// Format reassembly
	//////////////////////////////
	always_comb begin
		case (immType)
			immI: imm = {{20{sign}}, instr[31:20]};
			immIz: imm = {20'b0, instr[31:20]};        // Zero-extended I form
			immS: imm = {{20{sign}}, instr[31:25], instr[11:7]};
			immB: begin
				imm = {{19{sign}}, instr[31], instr[7], // Bit 0 always zero
					instr[30:25], instr[11:8], 1'b0};
			end
			immU: imm = {instr[31:12], 12'b0};         // Upper 20 bits
			immJ: begin
				imm = {{11{sign}}, instr[31], instr[19:12],
					instr[20], instr[30:21], 1'b0};
			end
			default: imm = '0;
		endcase
	end

endmodule

/* logic/controlUnit.sv */
module controlUnit (
	input rvPkg::instrT instr,
	output rvPkg::ctrlT ctrl
);
	import rvPkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	aluOpT decAluOp;                                 // ALU op from funct fields

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	//////////////////////////////
	// ALU operation from funct
	//////////////////////////////
	always_comb begin
		decAluOp = aluAdd;
		case (funct3)
			3'b000: decAluOp = (funct7 == 7'b0100000 && opcode == opReg) ? aluSub : aluAdd;
			3'b001: decAluOp = aluSll;                 // SLL, SLLI
			3'b010: decAluOp = aluSlt;                 // SLT, SLTI
			3'b011: decAluOp = aluSltu;                // SLTU, SLTIU
			3'b100: decAluOp = aluXor;                 // XOR, XORI
			3'b101: decAluOp = (funct7 == 7'b0100000) ? aluSra : aluSrl;  // Both shift forms
			3'b110: decAluOp = aluOr;                  // OR, ORI
			3'b111: decAluOp = aluAnd;                 // AND, ANDI
			default: decAluOp = aluAdd;
		endcase
	end

	//////////////////////////////
	// Per-opcode control
	//////////////////////////////
	always_comb begin
		ctrl = '0;                                     // Unknown opcodes act as no-ops
		ctrl.funct3 = funct3;
		ctrl.rd = instr[11:7];
		ctrl.rs1 = instr[19:15];
		ctrl.rs2 = instr[24:20];
		case (opcode)
			opLui: begin
				ctrl.setDataZero = 1'b1;               // 0 + imm
				ctrl.immSel = 1'b1;
				ctrl.immType = immU;
				ctrl.regWriteEnable = 1'b1;
			end
			opAuipc: begin
				ctrl.pcOperand = 1'b1;                 // pc + imm
				ctrl.immSel = 1'b1;
				ctrl.immType = immU;
				ctrl.regWriteEnable = 1'b1;
			end
			opJal: begin
				ctrl.pcOperand = 1'b1;                 // Target pc + imm in ALU
				ctrl.immSel = 1'b1;
				ctrl.immType = immJ;
				ctrl.regWriteEnable = 1'b1;
				ctrl.addConstant4 = 1'b1;
				ctrl.jump = 1'b1;
				ctrl.jumpAL = 1'b1;
			end
			opJalr: begin
				ctrl.immSel = 1'b1;                    // Target rs1 + imm in ALU
				ctrl.immType = immI;
				ctrl.regWriteEnable = 1'b1;
				ctrl.addConstant4 = 1'b1;
				ctrl.jump = 1'b1;
			end
			opBranch: begin
				ctrl.branch = 1'b1;                    // Compare done in branchUnit
				ctrl.immSel = 1'b1;
				ctrl.immType = immB;
			end
			opLoad: begin
				ctrl.immSel = 1'b1;                    // Address rs1 + imm
				ctrl.immType = immI;
				ctrl.regWriteEnable = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memType = funct3;
			end
			opStore: begin
				ctrl.immSel = 1'b1;
				ctrl.immType = immS;
				ctrl.memWrite = 1'b1;
				ctrl.memType = funct3;
			end
			opImm: begin
				ctrl.immSel = 1'b1;
				ctrl.immType = immI;                   // Sign-extended for all
				ctrl.regWriteEnable = 1'b1;
				ctrl.aluOp = decAluOp;
			end
			opReg: begin
				ctrl.regWriteEnable = 1'b1;
				ctrl.aluOp = decAluOp;
			end
			default: ;
		endcase
	end

endmodule

/* logic/rvPkg.sv */
package rvPkg;

	//////////////////////////////
	// Widths
	//////////////////////////////
	localparam int xlen = 32;                       // Data and address width
	localparam int regIdxW = 5;                     // Register index width
	localparam int numRegs = 32;                    // Architectural registers

	typedef logic [xlen-1:0] xlenT;                 // Data or address word
	typedef logic [regIdxW-1:0] regIdxT;            // Register index
	typedef logic [31:0] instrT;                    // Raw instruction word
	typedef logic [2:0] memTypeT;                   // Load/store width code, funct3

	localparam xlenT pcStep = 32'd4;                // Sequential pc increment

	// Load/store width codes
	localparam memTypeT memByte = 3'd0;             // LB, SB
	localparam memTypeT memHalf = 3'd1;             // LH, SH
	localparam memTypeT memWord = 3'd2;             // LW, SW
	localparam memTypeT memByteU = 3'd4;            // LBU
	localparam memTypeT memHalfU = 3'd5;            // LHU

	//////////////////////////////
	// Opcodes
	//////////////////////////////
	localparam logic [6:0] opLui = 7'b0110111;
	localparam logic [6:0] opAuipc = 7'b0010111;
	localparam logic [6:0] opJal = 7'b1101111;
	localparam logic [6:0] opJalr = 7'b1100111;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opImm = 7'b0010011;     // Register-immediate ALU
	localparam logic [6:0] opReg = 7'b0110011;     // Register-register ALU

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluSll, aluSlt, aluSltu,
		aluXor, aluSrl, aluSra, aluOr, aluAnd
	} aluOpT;

	typedef enum logic [2:0] {
		immI, immIz, immS, immB, immU, immJ         // Iz is the zero-extended I form
	} immTypeT;

	// Decoded control bundle
	typedef struct packed {
		aluOpT aluOp;
		immTypeT immType;
		logic immSel;                               // ALU B takes the immediate
		logic setDataZero;                          // ALU A forced to zero
		logic regWriteEnable;
		logic memRead;
		logic memWrite;
		logic branch;
		logic pcOperand;                            // ALU A takes the pc
		logic jump;
		logic jumpAL;                               // Set for JAL, clear for JALR
		logic addConstant4;                         // Link value pc + 4
		memTypeT memType;
		logic [2:0] funct3;
		regIdxT rd;
		regIdxT rs1;
		regIdxT rs2;
	} ctrlT;

endpackage
